/* Bender.yml */
package:
  name: divmmc

sources:
  - include_dirs:
      - source
    files:
      - source/divmmc_pkg.sv
      - source/cpu_bus_decode.sv
      - source/divmmc_regs.sv
      - source/paging_ctrl.sv
      - source/spi_master.sv
      - source/divmmc_top.sv
  - target: test
    files:
      - verification/sd_card_model.sv
      - verification/divmmc_tb.sv

/* source/cpu_bus_decode.sv */
`default_nettype none

`include "divmmc_cfg.svh"

module cpu_bus_decode
   import divmmc_pkg::*;
(
   input  wire logic       clk_sys,
   input  wire logic       arst_n,
   input  wire cpu_bus_t   bus,
   input  wire logic [1:0] mode,
   input  wire logic       enable,
   output bus_event_t      evt
);

   logic       io_wr_c;
   logic       io_rd_c;
   logic       m1_c;
   logic       io_wr_old;
   logic       io_rd_old;
   logic       m1_old;
   logic       io_wr_q;
   logic       io_rd_q;
   logic       m1_q;
   logic [7:0] port;
   logic       mode_a;
   logic       mode_b;

   // Access conditions straight off the bus
   assign io_wr_c = ~bus.iorq_n & ~bus.wr_n & bus.m1_n;
   assign io_rd_c = ~bus.iorq_n & ~bus.rd_n & bus.m1_n;
   assign m1_c    = ~bus.mreq_n & ~bus.m1_n;

   always_ff @(posedge clk_sys or negedge arst_n) begin
      if (!arst_n) begin
         io_wr_old <= 1'b0;
         io_rd_old <= 1'b0;
         m1_old    <= 1'b0;
         io_wr_q   <= 1'b0;
         io_rd_q   <= 1'b0;
         m1_q      <= 1'b0;
      end else begin
         io_wr_old <= io_wr_c;
         io_rd_old <= io_rd_c;
         m1_old    <= m1_c;
         // Rising edge of each condition, only while enabled
         io_wr_q   <= enable & io_wr_c & ~io_wr_old;
         io_rd_q   <= enable & io_rd_c & ~io_rd_old;
         m1_q      <= enable & m1_c & ~m1_old;
      end
   end

   assign port   = bus.addr[7:0];
   assign mode_a = mode[0];         // Modes 1 and 3
   assign mode_b = (mode == 2'b10);

   always_comb begin
      evt            = '0;
      evt.io_wr      = io_wr_q;
      evt.io_rd      = io_rd_q;
      evt.m1_fetch   = m1_q;
      evt.refresh    = ~bus.rfsh_n;
      evt.hit_cs     = (mode_a && port == `PORT_CS_A) || (mode_b && port == `PORT_CS_B);
      evt.hit_io     = (mode_a && port == `PORT_IO_A) || (mode_b && port == `PORT_IO_B);
      evt.hit_memctl = (mode == 2'b11) && (port == `PORT_MEMCTL);
   end

   // A well-formed bus never starts two kinds of access at once
   a_one_access: assert property (
      @(posedge clk_sys) disable iff (!arst_n)
      $onehot0({evt.io_wr, evt.io_rd, evt.m1_fetch})
   ) else $error("cpu_bus_decode: overlapping access strobes");

endmodule

`default_nettype wire

/* source/divmmc_cfg.svh */
`ifndef DIVMMC_CFG_SVH
`define DIVMMC_CFG_SVH

// Low address byte of each I/O port
`define PORT_CS_A      8'hE7    // Card select, modes 1 and 3
`define PORT_IO_A      8'hEB    // SPI data, modes 1 and 3
`define PORT_CS_B      8'h1F    // Card select, mode 2
`define PORT_IO_B      8'h3F    // SPI data, mode 2
`define PORT_MEMCTL    8'hE3    // Memory control, mode 3 only

// Entry points that arm the automapper
`define TRAP_ENTRY_0   16'h0000
`define TRAP_ENTRY_1   16'h0008
`define TRAP_ENTRY_2   16'h0038
`define TRAP_ENTRY_3   16'h0066

// Tape loader hooks, suppressed by disable_pagein
`define TRAP_TAPE_0    16'h04C6
`define TRAP_TAPE_1    16'h0562

// High byte of the page that maps in without waiting for refresh
`define TRAP_ROM_HI    8'h3D

// Start of the eight exit addresses
`define TRAP_EXIT_BASE 16'h1FF8

// RAM bank seen on page 0 when mapram is set
`define PAGE0_BANK     4'd3

`define SPI_BITS       8

`endif

/* source/divmmc_pkg.sv */
`default_nettype none

package divmmc_pkg;

   // Raw CPU bus, strobes are active low
   typedef struct packed {
      logic        wr_n;
      logic        rd_n;
      logic        mreq_n;
      logic        rfsh_n;
      logic        iorq_n;
      logic        m1_n;
      logic [15:0] addr;
   } cpu_bus_t;

   // Decoded bus activity
   typedef struct packed {
      logic io_wr;        // One cycle per I/O write
      logic io_rd;        // One cycle per I/O read
      logic m1_fetch;     // One cycle per opcode fetch
      logic refresh;      // High while a refresh cycle runs
      logic hit_cs;
      logic hit_io;
      logic hit_memctl;
   } bus_event_t;

   typedef struct packed {
      logic       conmem;
      logic       mapram;
      logic [1:0] unused;
      logic [3:0] sram_page;
   } memctl_t;

   typedef struct packed {
      logic [6:0] unused;
      logic       ss;
   } cs_byte_t;

   // Same data byte, read by whichever port was hit
   typedef union packed {
      memctl_t    ctl;
      cs_byte_t   cs;
      logic [7:0] raw;
   } io_data_u;

   typedef struct packed {
      logic       conmem;
      logic       mapram;
      logic [3:0] sram_page;
   } map_ctl_t;

endpackage

`default_nettype wire

/* source/divmmc_regs.sv */
`default_nettype none

module divmmc_regs
   import divmmc_pkg::*;
(
   input  wire logic       clk_sys,
   input  wire logic       arst_n,
   input  wire logic       enable,
   input  wire bus_event_t evt,
   input  wire io_data_u   din,
   output logic            spi_ss,
   output map_ctl_t        map,
   output logic            tx_start,
   output logic            rx_start,
   output logic [7:0]      tx_byte
);

   logic spi_wr;
   logic spi_rd;

   assign spi_wr = evt.io_wr & evt.hit_io;
   assign spi_rd = evt.io_rd & evt.hit_io;

   always_ff @(posedge clk_sys or negedge arst_n) begin
      if (!arst_n) begin
         spi_ss   <= 1'b1;   // Card deselected
         map      <= '0;
         tx_start <= 1'b0;
         rx_start <= 1'b0;
      end else begin
         tx_start <= enable & spi_wr;
         rx_start <= enable & spi_rd;
         if (!enable) begin
            spi_ss <= 1'b1;
            map    <= '0;
         end else begin
            if (evt.io_wr && evt.hit_cs)
               spi_ss <= din.cs.ss;
            if (evt.io_wr && evt.hit_memctl) begin
               map.conmem    <= din.ctl.conmem;
               map.mapram    <= din.ctl.mapram;
               map.sram_page <= din.ctl.sram_page;
            end
         end
      end
   end

   // Byte handed to the shifter with the start strobe
   always_ff @(posedge clk_sys) begin
      if (spi_wr)
         tx_byte <= din.raw;
      else if (spi_rd)
         tx_byte <= 8'hFF;   // Reads clock out all ones
   end

   a_start_excl: assert property (
      @(posedge clk_sys) disable iff (!arst_n)
      !(tx_start && rx_start)
   ) else $error("divmmc_regs: tx_start and rx_start together");

endmodule

`default_nettype wire

/* source/divmmc_top.sv */
`default_nettype none

module divmmc_top
   import divmmc_pkg::*;
(
   input  wire logic       clk_sys,
   input  wire logic       arst_n,
   input  wire cpu_bus_t   bus,
   input  wire logic [1:0] mode,
   input  wire logic [7:0] din,
   output logic [7:0]      dout,
   input  wire logic       enable,
   input  wire logic       disable_pagein,
   output logic            active_io,
   output logic            rom_active,
   output logic            ram_active,
   output logic [3:0]      ram_bank,
   output logic            spi_ss,
   output logic            spi_clk,
   output logic            spi_do,
   input  wire logic       spi_di
);

   bus_event_t evt;
   map_ctl_t   map;
   logic       tx_start;
   logic       rx_start;
   logic [7:0] tx_byte;

   assign active_io = evt.hit_io;   // SPI data port is being addressed

   cpu_bus_decode u_bus_decode (
      .clk_sys (clk_sys),
      .arst_n  (arst_n),
      .bus     (bus),
      .mode    (mode),
      .enable  (enable),
      .evt     (evt)
   );

   divmmc_regs u_regs (
      .clk_sys  (clk_sys),
      .arst_n   (arst_n),
      .enable   (enable),
      .evt      (evt),
      .din      (din),
      .spi_ss   (spi_ss),
      .map      (map),
      .tx_start (tx_start),
      .rx_start (rx_start),
      .tx_byte  (tx_byte)
   );

   paging_ctrl u_paging (
      .clk_sys        (clk_sys),
      .arst_n         (arst_n),
      .enable         (enable),
      .mode           (mode),
      .evt            (evt),
      .addr           (bus.addr),
      .rfsh_n         (bus.rfsh_n),
      .disable_pagein (disable_pagein),
      .map            (map),
      .rom_active     (rom_active),
      .ram_active     (ram_active),
      .ram_bank       (ram_bank)
   );

   spi_master u_spi (
      .clk_sys  (clk_sys),
      .arst_n   (arst_n),
      .tx_start (tx_start),
      .rx_start (rx_start),
      .tx_byte  (tx_byte),
      .dout     (dout),
      .spi_clk  (spi_clk),
      .spi_do   (spi_do),
      .spi_di   (spi_di)
   );

endmodule

`default_nettype wire

/* source/paging_ctrl.sv */
`default_nettype none

`include "divmmc_cfg.svh"

module paging_ctrl
   import divmmc_pkg::*;
(
   input  wire logic        clk_sys,
   input  wire logic        arst_n,
   input  wire logic        enable,
   input  wire logic [1:0]  mode,
   input  wire bus_event_t  evt,
   input  wire logic [15:0] addr,
   input  wire logic        rfsh_n,
   input  wire logic        disable_pagein,
   input  wire map_ctl_t    map,
   output logic             rom_active,
   output logic             ram_active,
   output logic [3:0]       ram_bank
);

   logic trigger;
   logic automap;
   logic hit_entry;
   logic hit_tape;
   logic hit_rom_hi;
   logic hit_exit;
   logic page0;
   logic page1;

   assign hit_entry  = (addr == `TRAP_ENTRY_0) || (addr == `TRAP_ENTRY_1) ||
                       (addr == `TRAP_ENTRY_2) || (addr == `TRAP_ENTRY_3);
   assign hit_tape   = (addr == `TRAP_TAPE_0) || (addr == `TRAP_TAPE_1);
   assign hit_rom_hi = (addr[15:8] == `TRAP_ROM_HI);
   assign hit_exit   = ((addr & 16'hFFF8) == `TRAP_EXIT_BASE);   // 1FF8 to 1FFF

   // Trigger is armed by a fetch and copied to automap on refresh
   always_ff @(posedge clk_sys or negedge arst_n) begin
      if (!arst_n) begin
         trigger <= 1'b0;
         automap <= 1'b0;
      end else if (!enable || mode != 2'b11) begin
         trigger <= 1'b0;
         automap <= 1'b0;
      end else begin
         if (evt.m1_fetch) begin
            if (hit_entry) begin
               trigger <= 1'b1;
            end else if (hit_tape) begin
               trigger <= ~disable_pagein;
            end else if (hit_rom_hi) begin
               trigger <= 1'b1;
               automap <= 1'b1;   // No wait for refresh
            end else if (hit_exit) begin
               trigger <= 1'b0;
            end
         end
         if (evt.refresh)
            automap <= trigger;
      end
   end

   assign page0 = (addr[15:13] == 3'b000);
   assign page1 = (addr[15:13] == 3'b001);

   // Overlay select
   always_comb begin
      rom_active = rfsh_n & page0 & (map.conmem | (automap & ~map.mapram));
      ram_active = (rfsh_n & page0 & automap & map.mapram & ~map.conmem) |
                   (page1 & (map.conmem | automap));
      ram_bank   = page0 ? `PAGE0_BANK : map.sram_page;
   end

   // Automap only switches on from an armed trigger or a 3Dxx fetch
   a_automap_src: assert property (
      @(posedge clk_sys) disable iff (!arst_n)
      $rose(automap) |-> $past(trigger || (evt.m1_fetch && hit_rom_hi))
   ) else $error("paging_ctrl: automap set without a trigger");

endmodule

`default_nettype wire

/* source/spi_master.sv */
`default_nettype none

`include "divmmc_cfg.svh"

module spi_master (
   input  wire logic       clk_sys,
   input  wire logic       arst_n,
   input  wire logic       tx_start,
   input  wire logic       rx_start,
   input  wire logic [7:0] tx_byte,
   output logic [7:0]      dout,
   output logic            spi_clk,
   output logic            spi_do,
   input  wire logic       spi_di
);

   // Last half cycle of a byte
   localparam logic [3:0] HALF_LAST = 4'(2 * `SPI_BITS - 1);

   logic                 busy;
   logic [3:0]           cnt;      // Half-cycle counter
   logic                 clk_q;
   logic [`SPI_BITS-1:0] sreg;     // Full-duplex shift register
   logic                 rx_bit;   // Bit sampled on the rising edge
   logic                 start;

   // Starts during a transfer are ignored
   assign start = (tx_start | rx_start) & ~busy;

   always_ff @(posedge clk_sys or negedge arst_n) begin
      if (!arst_n) begin
         busy  <= 1'b0;
         cnt   <= '0;
         clk_q <= 1'b0;
         dout  <= '0;
      end else if (!busy) begin
         if (start) begin
            busy  <= 1'b1;
            cnt   <= '0;
            clk_q <= 1'b0;
         end
      end else begin
         clk_q <= ~clk_q;
         cnt   <= cnt + 4'd1;
         if (cnt == HALF_LAST) begin
            busy  <= 1'b0;
            clk_q <= 1'b0;   // Back to idle low
            dout  <= {sreg[`SPI_BITS-2:0], rx_bit};
         end
      end
   end

   // Even count means spi_clk is about to rise
   always_ff @(posedge clk_sys) begin
      if (start) begin
         sreg <= tx_byte;
      end else if (busy) begin
         if (!cnt[0])
            rx_bit <= spi_di;
         else
            sreg <= {sreg[`SPI_BITS-2:0], rx_bit};   // Falling edge
      end
   end

   assign spi_clk = clk_q;
   assign spi_do  = busy & sreg[`SPI_BITS-1];   // MSB first

   a_clk_idle: assert property (
      @(posedge clk_sys) disable iff (!arst_n)
      !busy |-> !spi_clk
   ) else $error("spi_master: spi_clk high while idle");

endmodule

`default_nettype wire

/* src.f */
+incdir+source
source/divmmc_pkg.sv
source/cpu_bus_decode.sv
source/divmmc_regs.sv
source/paging_ctrl.sv
source/spi_master.sv
source/divmmc_top.sv
verification/sd_card_model.sv
verification/divmmc_tb.sv

/* verification/divmmc_tb.sv */
`default_nettype none

module divmmc_tb
   import divmmc_pkg::*;
();
   timeunit 1ns;
   timeprecision 100ps;

   localparam logic [2:0] OP_IDLE     = 3'd0;
   localparam logic [2:0] OP_WR       = 3'd1;
   localparam logic [2:0] OP_RD       = 3'd2;
   localparam logic [2:0] OP_FETCH    = 3'd3;   // Opcode fetch only
   localparam logic [2:0] OP_FETCH_RF = 3'd4;   // Fetch followed by refresh

   typedef struct packed {
      logic [2:0]  op;
      logic [1:0]  mode;
      logic [15:0] addr;
      logic [7:0]  data;
      logic        en;
      logic        dis;
      logic        rom;      // Expected from here on
      logic        ram;
      logic [3:0]  bank;
      logic        ss;
      logic        io;
      logic [7:0]  dout;
      logic        spi;      // One SPI byte runs
      logic [7:0]  card;     // Byte the card holds afterwards
   } step_t;

   logic        clk_sys = 1'b0;
   logic        arst_n;
   cpu_bus_t    bus;
   logic [1:0]  mode;
   logic [7:0]  din;
   logic [7:0]  dout;
   logic        enable;
   logic        disable_pagein;
   logic        active_io;
   logic        rom_active;
   logic        ram_active;
   logic [3:0]  ram_bank;
   logic        spi_ss;
   logic        spi_clk;
   logic        spi_do;
   logic        spi_di;

   // Reference state
   map_ctl_t    r_map  = '0;
   logic        r_ss   = 1'b1;
   logic        r_trig = 1'b0;
   logic        r_auto = 1'b0;
   logic [7:0]  r_card = 8'hA5;   // Byte the card sends next
   logic [7:0]  r_dout = 8'h00;

   step_t       tbl [32];
   int          n_steps = 0;
   int          errors  = 0;
   integer      seed    = 36141;
   int          spi_rises = 0;
   int          rises_before;

   always #10 clk_sys = ~clk_sys;

   // Count SPI clock pulses
   always @(posedge spi_clk) spi_rises++;

   divmmc_top u_divmmc_top (.*);

   sd_card_model u_card (.spi_clk, .spi_do, .spi_di);

   function automatic logic [7:0] rnd_byte();
      logic [31:0] r;
      r = $random(seed);
      return r[7:0];
   endfunction

   task automatic append_step(input logic [2:0] op, input logic [1:0] md,
                              input logic [15:0] a, input logic [7:0] d,
                              input logic en, input logic dis);
      logic cs_hit;
      logic io_hit;
      logic mc_hit;
      logic spi_xfer;
      logic page0;
      logic page1;
      cs_hit = (md[0] && a[7:0] == 8'hE7) || (md == 2'd2 && a[7:0] == 8'h1F);
      io_hit = (md[0] && a[7:0] == 8'hEB) || (md == 2'd2 && a[7:0] == 8'h3F);
      mc_hit = (md == 2'd3) && (a[7:0] == 8'hE3);
      spi_xfer = en && (op == OP_WR || op == OP_RD) && io_hit;
      if (en && op == OP_WR && cs_hit)
         r_ss = d[0];
      if (en && op == OP_WR && mc_hit)
         r_map = {d[7:6], d[3:0]};
      if (spi_xfer) begin
         r_dout = r_card;                       // Card answers with its last byte
         r_card = (op == OP_WR) ? d : 8'hFF;
      end
      if (op == OP_FETCH || op == OP_FETCH_RF) begin
         if (a == 16'h0000 || a == 16'h0008 || a == 16'h0038 || a == 16'h0066)
            r_trig = 1'b1;
         else if (a == 16'h04C6 || a == 16'h0562)
            r_trig = !dis;
         else if (a[15:8] == 8'h3D) begin
            r_trig = 1'b1;
            r_auto = 1'b1;
         end else if (a >= 16'h1FF8 && a <= 16'h1FFF)
            r_trig = 1'b0;
         if (op == OP_FETCH_RF)
            r_auto = r_trig;
      end
      if (!en || md != 2'd3) begin
         r_trig = 1'b0;
         r_auto = 1'b0;
      end
      if (!en) begin
         r_ss  = 1'b1;
         r_map = '0;
      end
      page0 = (a[15:13] == 3'd0);
      page1 = (a[15:13] == 3'd1);
      tbl[n_steps] = {op, md, a, d, en, dis,
                      page0 && (r_map.conmem || (r_auto && !r_map.mapram)),
                      (page0 && r_auto && r_map.mapram && !r_map.conmem) ||
                         (page1 && (r_map.conmem || r_auto)),
                      page0 ? 4'd3 : r_map.sram_page, r_ss, io_hit, r_dout,
                      spi_xfer, r_card};
      n_steps++;
   endtask

   task automatic run_step(input step_t s);
      @(posedge clk_sys);
      #2;
      mode           = s.mode;
      enable         = s.en;
      disable_pagein = s.dis;
      din            = s.data;
      bus            = {6'b111111, s.addr};   // All strobes idle
      case (s.op)
         OP_WR: begin
            bus.iorq_n = 1'b0;
            bus.wr_n   = 1'b0;
         end
         OP_RD: begin
            bus.iorq_n = 1'b0;
            bus.rd_n   = 1'b0;
         end
         OP_FETCH, OP_FETCH_RF: begin
            bus.mreq_n = 1'b0;
            bus.m1_n   = 1'b0;
         end
         default: ;
      endcase
      repeat (3) @(posedge clk_sys);
      #2;
      if (s.op == OP_FETCH_RF) begin
         bus.m1_n   = 1'b1;
         bus.rfsh_n = 1'b0;
         repeat (2) @(posedge clk_sys);
         #2;
      end
      bus = {6'b111111, s.addr};
      // I/O accesses may start an SPI byte
      repeat ((s.op == OP_WR || s.op == OP_RD) ? 20 : 2) @(posedge clk_sys);
   endtask

   task automatic compare(input string what, input logic [7:0] got,
                          input logic [7:0] exp, input int step);
      if (got !== exp) begin
         errors++;
         $display("ERROR %0t ns: step %0d, %s is %0h, expected %0h",
                  $time, step, what, got, exp);
      end
   endtask

   // Watchdog allows 40 cycles per table step
   initial begin
      #1;
      #(n_steps * 40 * 20);
      $display("Watchdog expired before the stimulus table finished");
      $display("test failed");
      $finish;
   end

   initial begin
      arst_n         = 1'b0;
      bus            = {6'b111111, 16'h0000};
      mode           = 2'd0;
      din            = 8'h00;
      enable         = 1'b0;
      disable_pagein = 1'b0;
      append_step(OP_IDLE,     2'd3, 16'h0000, 8'h00, 1'b0, 1'b0);
      append_step(OP_WR,       2'd3, 16'h00E3, 8'hC5, 1'b0, 1'b0);
      append_step(OP_IDLE,     2'd3, 16'h2000, 8'h00, 1'b1, 1'b0);
      append_step(OP_WR,       2'd1, 16'h00E7, 8'hFE, 1'b1, 1'b0);
      append_step(OP_WR,       2'd1, 16'h001F, 8'h01, 1'b1, 1'b0);
      append_step(OP_WR,       2'd2, 16'h001F, 8'h01, 1'b1, 1'b0);
      append_step(OP_WR,       2'd3, 16'h00E7, 8'h00, 1'b1, 1'b0);
      append_step(OP_IDLE,     2'd2, 16'h003F, 8'h00, 1'b1, 1'b0);
      append_step(OP_WR,       2'd1, 16'h00EB, rnd_byte(), 1'b1, 1'b0);
      append_step(OP_WR,       2'd1, 16'h00EB, rnd_byte(), 1'b1, 1'b0);
      append_step(OP_RD,       2'd1, 16'h00EB, 8'h00, 1'b1, 1'b0);
      append_step(OP_WR,       2'd2, 16'h003F, rnd_byte(), 1'b1, 1'b0);
      append_step(OP_RD,       2'd2, 16'h003F, 8'h00, 1'b1, 1'b0);
      append_step(OP_RD,       2'd1, 16'h003F, 8'h00, 1'b1, 1'b0);
      append_step(OP_WR,       2'd1, 16'h00E3, 8'h80 | (rnd_byte() & 8'h0F), 1'b1, 1'b0);
      append_step(OP_WR,       2'd3, 16'h00E3, 8'h80 | (rnd_byte() & 8'h0F), 1'b1, 1'b0);
      append_step(OP_IDLE,     2'd3, 16'h2100, 8'h00, 1'b1, 1'b0);
      append_step(OP_WR,       2'd3, 16'h00E3, 8'h00, 1'b1, 1'b0);
      append_step(OP_FETCH_RF, 2'd3, 16'h0038, 8'h00, 1'b1, 1'b0);
      append_step(OP_FETCH_RF, 2'd3, 16'h1FFB, 8'h00, 1'b1, 1'b0);
      append_step(OP_FETCH,    2'd3, 16'h3D00, 8'h00, 1'b1, 1'b0);
      append_step(OP_FETCH_RF, 2'd3, 16'h1FF8, 8'h00, 1'b1, 1'b0);
      append_step(OP_FETCH_RF, 2'd3, 16'h04C6, 8'h00, 1'b1, 1'b1);
      append_step(OP_FETCH_RF, 2'd3, 16'h04C6, 8'h00, 1'b1, 1'b0);
      append_step(OP_WR,       2'd3, 16'h00E3, 8'h40 | (rnd_byte() & 8'h0F), 1'b1, 1'b0);
      append_step(OP_IDLE,     2'd3, 16'h0100, 8'h00, 1'b0, 1'b0);
      append_step(OP_IDLE,     2'd3, 16'h2100, 8'h00, 1'b1, 1'b0);
      repeat (2) @(posedge clk_sys);
      #2 arst_n = 1'b1;
      for (int i = 0; i < n_steps; i++) begin
         rises_before = spi_rises;
         run_step(tbl[i]);
         @(negedge clk_sys);   // Sample mid cycle once outputs settle
         compare("rom_active", rom_active, tbl[i].rom, i);
         compare("ram_active", ram_active, tbl[i].ram, i);
         compare("ram_bank", ram_bank, tbl[i].bank, i);
         compare("spi_ss", spi_ss, tbl[i].ss, i);
         compare("active_io", active_io, tbl[i].io, i);
         compare("dout", dout, tbl[i].dout, i);
         compare("spi_clk", spi_clk, 8'h00, i);
         compare("spi_clk rises", 8'(spi_rises - rises_before),
                 tbl[i].spi ? 8'd8 : 8'd0, i);
         compare("card byte", u_card.last_rx, tbl[i].card, i);
      end
      $display("Ran %0d table steps, %0d errors", n_steps, errors);
      if (errors == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

endmodule

`default_nettype wire

/* verification/sd_card_model.sv */
`default_nettype none

module sd_card_model (
   input  wire logic spi_clk,
   input  wire logic spi_do,
   output logic      spi_di
);
   timeunit 1ns;
   timeprecision 100ps;

   logic [7:0] rx_sreg;
   logic [7:0] tx_sreg = 8'hA5;   // First answer
   logic [7:0] last_rx = 8'hA5;
   logic [2:0] nbits   = 3'd0;

   assign spi_di = tx_sreg[7];    // MSB first

   always @(posedge spi_clk) begin
      rx_sreg <= {rx_sreg[6:0], spi_do};
      nbits   <= nbits + 3'd1;
      if (nbits == 3'd7)
         last_rx <= {rx_sreg[6:0], spi_do};
   end

   // Next bit goes out on the falling edge
   always @(negedge spi_clk) begin
      if (nbits == 3'd0)
         tx_sreg <= last_rx;   // Whole byte in, echo it on the next one
      else
         tx_sreg <= {tx_sreg[6:0], 1'b0};
   end

endmodule

`default_nettype wire
